//--- Bender.yml
package:
  name: vmem_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/vmem_pkg.sv
      - src/address_scheduler.sv
      - src/data_memory.sv
      - src/vector_memory_stage.sv
      - src/vmem_subsystem.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/vmem_properties.sv
      - bench/vmem_subsystem_tb.sv

//--- all.f
+incdir+src
src/vmem_pkg.sv
src/address_scheduler.sv
src/data_memory.sv
src/vector_memory_stage.sv
src/vmem_subsystem.sv
bench/vmem_properties.sv
bench/vmem_subsystem_tb.sv

//--- bench/vmem_properties.sv
// Memory port and latch checks
`timescale 1ns/1ps
`include "vmem_consts.svh"

module vmem_properties import vmem_pkg::*; (
  input logic        CLK,
  input logic        nRST,
  input ex_mem_t     ex_in,
  input logic        stall,
  input logic        flush,
  input logic        busy,
  input logic        dhit,
  input mem_req_t    mem_req,
  input rob_result_t rob_out
);

  int error_count = 0;

  // Single port, nothing new goes out while a response returns
  a_one_outstanding: assert property (@(posedge CLK) disable iff (!nRST)
    (mem_req.ren || mem_req.wen) |-> !dhit)
    else begin
      $error("Memory request issued while a response was returning");
      error_count++;
    end

  // Each request covers one naturally aligned element
  a_elem_aligned: assert property (@(posedge CLK) disable iff (!nRST)
    (mem_req.ren || mem_req.wen) |->
      (((ex_in.eew == `EEW_8) && $onehot(mem_req.byte_ena)) ||
       ((ex_in.eew == `EEW_16) && ((mem_req.byte_ena == 4'b0011) ||
                                   (mem_req.byte_ena == 4'b1100))) ||
       ((ex_in.eew == `EEW_32) && (mem_req.byte_ena == 4'b1111))))
    else begin
      $error("Memory request byte enables do not cover an aligned element");
      error_count++;
    end

  // Ready only rises after a latch edge
  a_ready_after_latch: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(rob_out.ready) |-> $past(ex_in.valid && !busy && !stall && !flush))
    else begin
      $error("rob_out.ready rose without a latch");
      error_count++;
    end

endmodule

bind vector_memory_stage vmem_properties u_vmem_properties (
  .CLK     (CLK),
  .nRST    (nRST),
  .ex_in   (ex_in),
  .stall   (stall),
  .flush   (flush),
  .busy    (busy),
  .dhit    (dhit),
  .mem_req (mem_req),
  .rob_out (rob_out)
);

//--- bench/vmem_subsystem_tb.sv
// Vector memory subsystem testbench
`timescale 1ns/1ps
`include "vmem_consts.svh"

module vmem_subsystem_tb import vmem_pkg::*; ();

  localparam int TIMEOUT = 50;  // Cycles allowed for one bundle

  logic        CLK, nRST, stall, flush, busy;
  ex_mem_t     ex_in;
  rob_result_t rob_out;
  scalar_wb_t  wb_out;

  word_t model_mem [`VMEM_DEPTH];  // Mirrors every store issued
  word_t lcg_state;
  addr_t addr_a, addr_b;           // Word addresses shared by the tests
  int    errors, checks;

  vmem_subsystem u_vmem_subsystem (
    .CLK     (CLK),
    .nRST    (nRST),
    .ex_in   (ex_in),
    .stall   (stall),
    .flush   (flush),
    .rob_out (rob_out),
    .wb_out  (wb_out),
    .busy    (busy)
  );

  always #10 CLK = ~CLK;

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    errors++;
    $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  // Element bytes land at the address offset
  task automatic model_store(input addr_t a, input word_t d, input eew_t e);
    int nb;
    nb = 1 << e;
    for (int b = 0; b < nb; b++)
      model_mem[a[`VMEM_AWIDTH+1:2]][8*(a[1:0]+b) +: 8] = d[8*b +: 8];
  endtask

  function automatic word_t model_load(input addr_t a, input eew_t e);
    word_t w;
    w = model_mem[a[`VMEM_AWIDTH+1:2]] >> (8 * a[1:0]);
    if (e == `EEW_8)
      w = w & 32'h0000_00ff;
    else if (e == `EEW_16)
      w = w & 32'h0000_ffff;
    return w;
  endfunction

  function automatic ex_mem_t mem_bundle(input logic st, input eew_t e, input elem_idx_t idx,
                                         input elem_idx_t vl, input addr_t a0, input addr_t a1,
                                         input word_t s0, input word_t s1);
    ex_mem_t b;
    b            = '0;
    b.valid      = 1'b1;
    b.load_ena   = ~st;
    b.store_ena  = st;
    b.eew        = e;
    b.vd         = 5'd12;
    b.index      = idx;
    b.vl         = vl;
    b.result0    = a0;
    b.result1    = a1;
    b.storedata0 = s0;
    b.storedata1 = s1;
    return b;
  endfunction

  // Drive one bundle, wait for busy low, pass the latch edge
  task automatic run_bundle(input ex_mem_t b, output int cycles);
    ex_in  = b;
    cycles = 0;
    #1;
    while (busy && cycles < TIMEOUT) begin
      @(posedge CLK);
      #3;
      cycles++;
    end
    assert (!busy) else begin
      errors++;
      $display("Busy stayed high for %0d cycles at %0d ns", cycles, $time);
    end
    @(posedge CLK);
    #2;
    ex_in = '0;
  endtask

  task automatic check_rob(input logic [1:0] exp_wen, input logic exp_exc,
                           input word_t exp0, input word_t exp1);
    check_value("rob_out.ready", rob_out.ready, 1'b1);
    check_value("rob_out.exception", rob_out.exception, exp_exc);
    check_value("rob_out.wen", rob_out.wen, exp_wen);
    if (exp_wen[0])
      check_value("rob_out.wdata[31:0]", rob_out.wdata[31:0], exp0);
    if (exp_wen[1])
      check_value("rob_out.wdata[63:32]", rob_out.wdata[63:32], exp1);
  endtask

  task automatic store_pair(input eew_t e, input elem_idx_t vl, input addr_t a0,
                            input addr_t a1);
    word_t d0, d1;
    int    cyc;
    d0 = lcg_next();
    d1 = lcg_next();
    run_bundle(mem_bundle(1'b1, e, 6'd0, vl, a0, a1, d0, d1), cyc);
    model_store(a0, d0, e);
    if (vl > 1)
      model_store(a1, d1, e);
    check_value("busy cycles", cyc, (vl > 1) ? 3 : 1);
    check_rob(2'b00, 1'b0, '0, '0);  // Stores write no vd
  endtask

  task automatic load_words();
    int cyc;
    run_bundle(mem_bundle(1'b0, `EEW_32, 6'd0, 6'd2, addr_a, addr_b, '0, '0), cyc);
    check_rob(2'b11, 1'b0, model_load(addr_a, `EEW_32), model_load(addr_b, `EEW_32));
  endtask

  task automatic test_arith();
    ex_mem_t b;
    int      cyc;
    b            = '0;
    b.valid      = 1'b1;
    b.vd         = 5'd9;
    b.index      = 6'd4;
    b.vl         = 6'd6;
    b.result0    = lcg_next();
    b.result1    = lcg_next();
    b.wb.rd_wen  = 1'b1;
    b.wb.rd_sel  = 5'd17;
    b.wb.rd_data = lcg_next();
    run_bundle(b, cyc);
    check_value("busy cycles", cyc, 0);
    check_rob(2'b11, 1'b0, b.result0, b.result1);
    check_value("rob_out.vd", rob_out.vd, b.vd);
    check_value("rob_out.index", rob_out.index, b.index);
    check_value("wb_out", wb_out, b.wb);
    b.vl      = 6'd5;  // Lane 1 falls off the end
    b.result0 = lcg_next();
    run_bundle(b, cyc);
    check_rob(2'b01, 1'b0, b.result0, b.result1);
  endtask

  task automatic test_words();
    word_t w;
    w      = lcg_next();
    addr_a = {22'd0, 1'b0, w[6:0], 2'b00};
    w      = lcg_next();
    addr_b = {22'd0, 1'b1, w[6:0], 2'b00};  // Upper half keeps it apart from addr_a
    store_pair(`EEW_32, 6'd2, addr_a, addr_b);
    load_words();
  endtask

  task automatic test_subword();
    addr_t a0, a1;
    int    cyc;
    for (int off = 0; off < 4; off++) begin
      a0 = addr_a + off;
      a1 = addr_b + (3 - off);
      run_bundle(mem_bundle(1'b0, `EEW_8, 6'd0, 6'd2, a0, a1, '0, '0), cyc);
      check_rob(2'b11, 1'b0, model_load(a0, `EEW_8), model_load(a1, `EEW_8));
    end
    for (int off = 0; off < 4; off += 2) begin
      a0 = addr_a + off;
      a1 = addr_b + (2 - off);
      run_bundle(mem_bundle(1'b0, `EEW_16, 6'd0, 6'd2, a0, a1, '0, '0), cyc);
      check_rob(2'b11, 1'b0, model_load(a0, `EEW_16), model_load(a1, `EEW_16));
    end
    store_pair(`EEW_8, 6'd2, addr_a + 1, addr_b + 3);
    store_pair(`EEW_16, 6'd2, addr_a + 2, addr_b);
    load_words();
  endtask

  task automatic test_lane0();
    int cyc;
    store_pair(`EEW_32, 6'd1, addr_a, addr_b);  // addr_b must survive
    run_bundle(mem_bundle(1'b0, `EEW_32, 6'd5, 6'd6, addr_a, addr_b, '0, '0), cyc);
    check_value("busy cycles", cyc, 1);
    check_rob(2'b01, 1'b0, model_load(addr_a, `EEW_32), '0);
    load_words();
  endtask

  task automatic test_misaligned();
    int cyc;
    run_bundle(mem_bundle(1'b1, `EEW_16, 6'd0, 6'd2, addr_a + 1, addr_b,
                          lcg_next(), lcg_next()), cyc);
    check_value("busy cycles", cyc, 0);
    check_rob(2'b00, 1'b1, '0, '0);
    run_bundle(mem_bundle(1'b1, `EEW_32, 6'd0, 6'd2, addr_a, addr_b + 2,
                          lcg_next(), lcg_next()), cyc);
    check_rob(2'b00, 1'b1, '0, '0);
    load_words();
  endtask

  task automatic test_stall_flush();
    ex_mem_t     b;
    rob_result_t held_rob;
    scalar_wb_t  held_wb;
    int          cyc;
    b            = '0;
    b.valid      = 1'b1;
    b.vl         = 6'd2;
    b.result0    = lcg_next();
    b.result1    = lcg_next();
    b.wb.rd_wen  = 1'b1;
    b.wb.rd_sel  = 5'd5;
    b.wb.rd_data = lcg_next();
    run_bundle(b, cyc);
    held_rob  = rob_out;
    held_wb   = wb_out;
    stall     = 1'b1;
    b.result0 = lcg_next();  // Next bundle waits behind the stall
    ex_in     = b;
    repeat (4) begin
      @(posedge CLK);
      #2;
      check_value("rob_out", rob_out, held_rob);
      check_value("wb_out", wb_out, held_wb);
    end
    flush = 1'b1;
    @(posedge CLK);
    #2;
    flush = 1'b0;
    stall = 1'b0;
    ex_in = '0;
    check_value("rob_out.ready", rob_out.ready, 1'b0);
    check_value("rob_out.wen", rob_out.wen, 2'b00);
    check_value("wb_out.rd_wen", wb_out.rd_wen, 1'b0);
  endtask

  initial begin
    CLK       = 1'b0;
    nRST      = 1'b0;
    stall     = 1'b0;
    flush     = 1'b0;
    ex_in     = '0;
    lcg_state = 32'd7;
    errors    = 0;
    checks    = 0;
    repeat (8) @(posedge CLK);
    #2;
    nRST = 1'b1;
    check_value("rob_out.ready", rob_out.ready, 1'b0);
    check_value("rob_out.wen", rob_out.wen, 2'b00);
    check_value("wb_out.rd_wen", wb_out.rd_wen, 1'b0);
    test_arith();
    test_words();
    test_subword();
    test_lane0();
    test_misaligned();
    test_stall_flush();
    errors += u_vmem_subsystem.u_vector_memory_stage.u_vmem_properties.error_count;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- src/address_scheduler.sv
// Two-lane address scheduler
`timescale 1ns/1ps
`include "vmem_consts.svh"

module address_scheduler import vmem_pkg::*; (
  input  logic         CLK,
  input  logic         nRST,
  input  ex_mem_t      ex_in,
  input  logic         dhit,
  output mem_req_t     mem_req,
  output logic         busy,
  output logic         exception,
  output logic         arrived0,
  output logic [1:0]   offset0,
  output logic [1:0]   offset1
);

  sched_state_t state, next_state;

  addr_t      addr0, addr1, cur_addr;
  word_t      cur_sdata;
  logic [1:0] cur_off;
  byte_ena_t  elem_mask;
  logic       act0, act1;
  logic       mem_op, go, issue;

  // Element must sit on its natural boundary
  function automatic logic misaligned(input addr_t a, input eew_t e);
    case (e)
      `EEW_8:  misaligned = 1'b0;
      `EEW_16: misaligned = a[0];
      default: misaligned = |a[1:0];
    endcase
  endfunction

  assign addr0 = ex_in.result0;
  assign addr1 = ex_in.result1;

  assign offset0 = addr0[1:0];
  assign offset1 = addr1[1:0];

  // Lane k active while index + k < vl
  assign act0 = ex_in.index < ex_in.vl;
  assign act1 = ({1'b0, ex_in.index} + 7'd1) < {1'b0, ex_in.vl};

  assign mem_op    = ex_in.valid & (ex_in.load_ena | ex_in.store_ena);
  assign exception = mem_op & ((act0 & misaligned(addr0, ex_in.eew)) |
                               (act1 & misaligned(addr1, ex_in.eew)));
  assign go        = mem_op & act0 & ~exception;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Lane 0 goes out in the cycle the bundle shows up,
  // lane 1 one cycle after lane 0 returns
  always_comb begin
    next_state = state;
    busy       = 1'b0;
    issue      = 1'b0;
    arrived0   = 1'b0;
    case (state)
      IDLE: begin
        if (go) begin
          issue      = 1'b1;
          busy       = 1'b1;
          next_state = LANE0;
        end
      end
      LANE0: begin
        busy = 1'b1;
        if (dhit) begin
          arrived0 = 1'b1;
          if (act1) begin
            next_state = LANE1;
          end else begin
            busy       = 1'b0;                       // Single lane finishes here
            next_state = ex_in.valid ? IDLE : DONE;  // Valid drops while stalled
          end
        end
      end
      LANE1: begin
        if (dhit) begin
          next_state = ex_in.valid ? IDLE : DONE;
        end else begin
          // No hit yet means lane 1 is not in flight
          busy  = 1'b1;
          issue = 1'b1;
        end
      end
      DONE: begin
        // Held bundle reappears once the stall clears
        if (ex_in.valid) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  // Current lane selection
  assign cur_addr  = (state == LANE1) ? addr1 : addr0;
  assign cur_sdata = (state == LANE1) ? ex_in.storedata1 : ex_in.storedata0;
  assign cur_off   = cur_addr[1:0];

  always_comb begin
    case (ex_in.eew)
      `EEW_8:  elem_mask = 4'b0001;
      `EEW_16: elem_mask = 4'b0011;
      default: elem_mask = 4'b1111;
    endcase
  end

  assign mem_req.ren        = issue & ex_in.load_ena;
  assign mem_req.wen        = issue & ex_in.store_ena & ~ex_in.load_ena;
  assign mem_req.addr       = {cur_addr[31:2], 2'b00};
  assign mem_req.byte_ena   = elem_mask << cur_off;
  assign mem_req.store_data = cur_sdata << {cur_off, 3'b000};  // Place element at its byte lane

endmodule

//--- src/data_memory.sv
// Single-port data memory
`timescale 1ns/1ps
`include "vmem_consts.svh"

module data_memory import vmem_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  mem_req_t mem_req,
  output word_t    rdata,
  output logic     dhit
);

  word_t mem [`VMEM_DEPTH];

  logic [`VMEM_AWIDTH-1:0] widx;

  // Word index from the byte address
  assign widx = mem_req.addr[`VMEM_AWIDTH+1:2];

  // Byte-masked write
  always_ff @(posedge CLK) begin
    if (mem_req.wen) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_req.byte_ena[b]) begin
          mem[widx][8*b +: 8] <= mem_req.store_data[8*b +: 8];
        end
      end
    end
  end

  // Read data stays put until the next read
  always_ff @(posedge CLK) begin
    if (mem_req.ren) begin
      rdata <= mem[widx];
    end
  end

  // Hit one cycle after any request
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dhit <= 1'b0;
    end else begin
      dhit <= mem_req.ren | mem_req.wen;
    end
  end

endmodule

//--- src/vector_memory_stage.sv
// Vector memory stage
`timescale 1ns/1ps
`include "vmem_consts.svh"

module vector_memory_stage import vmem_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  ex_mem_t     ex_in,
  input  logic        stall,
  input  logic        flush,
  input  word_t       rdata,
  input  logic        dhit,
  output mem_req_t    mem_req,
  output logic        busy,
  output rob_result_t rob_out,
  output scalar_wb_t  wb_out
);

  ex_mem_t     sched_in;
  logic        exception, arrived0;
  logic [1:0]  offset0, offset1;
  word_t       load_buf;
  word_t       lane0_raw;
  word_t       lane0_word, lane1_word;
  logic        act0, act1;
  logic [1:0]  lane_wen;
  rob_result_t next_rob;

  // Shift down to the element, zero extend to eew
  function automatic word_t align_load(input word_t w, input logic [1:0] off,
                                       input eew_t e);
    word_t shifted;
    shifted = w >> {off, 3'b000};
    case (e)
      `EEW_8:  align_load = word_t'(shifted[7:0]);
      `EEW_16: align_load = word_t'(shifted[15:0]);
      default: align_load = shifted;
    endcase
  endfunction

  // Hold off new accesses during a stall
  always_comb begin
    sched_in       = ex_in;
    sched_in.valid = ex_in.valid & ~stall;
  end

  address_scheduler u_address_scheduler (
    .CLK       (CLK),
    .nRST      (nRST),
    .ex_in     (sched_in),
    .dhit      (dhit),
    .mem_req   (mem_req),
    .busy      (busy),
    .exception (exception),
    .arrived0  (arrived0),
    .offset0   (offset0),
    .offset1   (offset1)
  );

  // Lane 0 word parks here until lane 1 returns
  always_ff @(posedge CLK) begin
    if (arrived0) begin
      load_buf <= rdata;
    end
  end

  // Single-lane loads latch on the lane 0 hit itself
  assign lane0_raw = arrived0 ? rdata : load_buf;

  assign lane0_word = ex_in.load_ena ? align_load(lane0_raw, offset0, ex_in.eew)
                                     : ex_in.result0;
  assign lane1_word = ex_in.load_ena ? align_load(rdata, offset1, ex_in.eew)
                                     : ex_in.result1;

  assign act0 = ex_in.index < ex_in.vl;
  assign act1 = ({1'b0, ex_in.index} + 7'd1) < {1'b0, ex_in.vl};

  // Stores leave vd alone
  assign lane_wen = {act1, act0} & {2{ex_in.valid & ~exception & ~ex_in.store_ena}};

  always_comb begin
    next_rob.ready     = ex_in.valid;
    next_rob.exception = exception;
    next_rob.index     = ex_in.index;
    next_rob.vd        = ex_in.vd;
    next_rob.wen       = lane_wen;
    next_rob.wdata     = {lane1_word, lane0_word};
  end

  // Pipeline latch toward the ROB and scalar writeback
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rob_out <= '0;
      wb_out  <= '0;
    end else if (flush) begin
      rob_out <= '0;
      wb_out  <= '0;
    end else if (!stall) begin
      if (busy) begin
        // Bubble while memory is in flight
        rob_out.ready <= 1'b0;
        rob_out.wen   <= '0;
        wb_out.rd_wen <= 1'b0;
      end else begin
        rob_out <= next_rob;
        wb_out  <= ex_in.wb;
      end
    end
  end

endmodule

//--- src/vmem_consts.svh
// Vector memory stage constants
`ifndef VMEM_CONSTS_SVH
`define VMEM_CONSTS_SVH

// Lane data width, also the memory word width
`define VMEM_XLEN 32

// Data memory size in words
`define VMEM_DEPTH 256

// Word index bits taken from the byte address above bit 1
`define VMEM_AWIDTH 8

// Element width codes carried in the bundle
`define EEW_8  2'd0
`define EEW_16 2'd1
`define EEW_32 2'd2

`endif

//--- src/vmem_pkg.sv
// Vector memory stage types
`include "vmem_consts.svh"

package vmem_pkg;

  typedef logic [`VMEM_XLEN-1:0] word_t;   // One lane value or memory word
  typedef logic [31:0]           addr_t;   // Byte address
  typedef logic [1:0]            eew_t;
  typedef logic [4:0]            vreg_t;
  typedef logic [5:0]            elem_idx_t;  // Element index and vl
  typedef logic [3:0]            byte_ena_t;

  // Scalar result riding alongside the vector bundle
  typedef struct packed {
    logic        rd_wen;
    logic [4:0]  rd_sel;
    word_t       rd_data;
  } scalar_wb_t;

  typedef struct packed {
    logic       valid;
    logic       load_ena;
    logic       store_ena;
    eew_t       eew;
    vreg_t      vd;
    elem_idx_t  index;
    elem_idx_t  vl;
    word_t      result0;     // Lane address on load/store
    word_t      result1;
    word_t      storedata0;
    word_t      storedata1;
    scalar_wb_t wb;
  } ex_mem_t;

  typedef struct packed {
    logic        ready;
    logic        exception;
    elem_idx_t   index;
    vreg_t       vd;
    logic [1:0]  wen;
    logic [63:0] wdata;      // Lane 1 in the upper half
  } rob_result_t;

  typedef struct packed {
    logic      ren;
    logic      wen;
    addr_t     addr;         // Word aligned
    byte_ena_t byte_ena;
    word_t     store_data;
  } mem_req_t;

  typedef enum logic [1:0] {
    IDLE,
    LANE0,
    LANE1,
    DONE
  } sched_state_t;

endpackage

//--- src/vmem_subsystem.sv
// Vector memory subsystem top
`timescale 1ns/1ps

module vmem_subsystem import vmem_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  ex_mem_t     ex_in,
  input  logic        stall,
  input  logic        flush,
  output rob_result_t rob_out,
  output scalar_wb_t  wb_out,
  output logic        busy
);

  mem_req_t mem_req;
  word_t    rdata;
  logic     dhit;

  vector_memory_stage u_vector_memory_stage (
    .CLK     (CLK),
    .nRST    (nRST),
    .ex_in   (ex_in),
    .stall   (stall),
    .flush   (flush),
    .rdata   (rdata),
    .dhit    (dhit),
    .mem_req (mem_req),
    .busy    (busy),
    .rob_out (rob_out),
    .wb_out  (wb_out)
  );

  data_memory u_data_memory (
    .CLK     (CLK),
    .nRST    (nRST),
    .mem_req (mem_req),
    .rdata   (rdata),
    .dhit    (dhit)
  );

endmodule
